// File: verilog/lsq_cfg.svh
// Queue depth must be a power of two and LSQ_PTR_W its base-2 log; tags and data are unsigned
`ifndef LSQ_CFG_SVH
`define LSQ_CFG_SVH

// Number of queue slots
`define LSQ_ENTRIES 16

// Head and tail pointer width
`define LSQ_PTR_W 4

// Reorder buffer tag width
`define LSQ_ROB_TAG_W 5

// Memory response number width, zero means no response
`define LSQ_MEM_TAG_W 4

// Address and data width
`define LSQ_DATA_W 64

`endif

// File: verilog/lsq_pkg.sv
// Types are sized from the config macros; MEM_NONE must stay the all-zero command encoding
`include "lsq_cfg.svh"

package lsq_pkg;

  // Command to the tagged data memory
  typedef enum logic [1:0] {
    MEM_NONE  = 2'd0,
    MEM_LOAD  = 2'd1,
    MEM_STORE = 2'd2
  } mem_command_t;

  // Reorder buffer tag
  typedef logic [`LSQ_ROB_TAG_W-1:0] rob_tag_t;

  // Memory response number, nonzero when valid
  typedef logic [`LSQ_MEM_TAG_W-1:0] mem_tag_t;

  // Queue slot index
  typedef logic [`LSQ_PTR_W-1:0] lsq_ptr_t;

  // Address and data word
  typedef logic [`LSQ_DATA_W-1:0] data_t;

endpackage

// File: verilog/lsq_if.sv
// Both buses carry two lanes with lane 1 older; the RTL top drives them and the queue only reads

// Dispatch lanes, one memory operation per lane per cycle
interface lsq_disp_if import lsq_pkg::*; ();

  logic     valid_1;
  rob_tag_t tag_1;
  logic     is_load_1;

  logic     valid_2;
  rob_tag_t tag_2;
  logic     is_load_2;

  modport source (
    output valid_1, tag_1, is_load_1,
    output valid_2, tag_2, is_load_2
  );

  modport sink (
    input valid_1, tag_1, is_load_1,
    input valid_2, tag_2, is_load_2
  );

endinterface

// Execute writeback lanes with the computed address and store value
interface lsq_exec_if import lsq_pkg::*; ();

  logic     valid_1;
  rob_tag_t tag_1;
  data_t    addr_1;
  data_t    value_1;

  logic     valid_2;
  rob_tag_t tag_2;
  data_t    addr_2;
  data_t    value_2;

  modport source (
    output valid_1, tag_1, addr_1, value_1,
    output valid_2, tag_2, addr_2, value_2
  );

  modport sink (
    input valid_1, tag_1, addr_1, value_1,
    input valid_2, tag_2, addr_2, value_2
  );

endinterface

// File: verilog/lsq_entry.sv
// Tags must be unique among live slots; a store is ready only after a reorder-head match
module lsq_entry import lsq_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  logic     clear,
  input  logic     alloc_1,
  input  logic     alloc_2,
  lsq_disp_if.sink disp,
  lsq_exec_if.sink exec,
  input  logic     rob_head_valid_1,
  input  rob_tag_t rob_head_tag_1,
  input  logic     rob_head_valid_2,
  input  rob_tag_t rob_head_tag_2,
  output rob_tag_t tag,
  output data_t    addr,
  output data_t    value,
  output logic     is_load,
  output logic     ready
);

  // Control state
  logic valid_q;
  logic complete_q;
  logic head_met_q;

  // Payload
  rob_tag_t tag_q;
  logic     is_load_q;
  data_t    addr_q;
  data_t    value_q;

  logic     alloc;
  logic     valid_n;
  rob_tag_t tag_n;
  logic     hit_1;
  logic     hit_2;
  logic     exec_hit;
  logic     head_hit;

  assign alloc   = alloc_1 | alloc_2;
  assign valid_n = alloc | (valid_q & ~clear);

  // Tag as it will be after this edge, so a same-cycle dispatch can match
  assign tag_n = alloc_1 ? disp.tag_1 :
                 alloc_2 ? disp.tag_2 :
                 tag_q;

  assign hit_1    = exec.valid_1 & valid_n & (exec.tag_1 == tag_n);
  assign hit_2    = exec.valid_2 & valid_n & (exec.tag_2 == tag_n);
  assign exec_hit = hit_1 | hit_2;

  // Either reorder head slot may grant the store
  assign head_hit = valid_n &
                    ((rob_head_valid_1 & (rob_head_tag_1 == tag_n)) |
                     (rob_head_valid_2 & (rob_head_tag_2 == tag_n)));

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q    <= 1'b0;
      complete_q <= 1'b0;
      head_met_q <= 1'b0;
    end else begin
      valid_q <= valid_n;
      if (alloc) begin
        complete_q <= exec_hit;
        head_met_q <= head_hit;
      end else if (clear) begin
        complete_q <= 1'b0;
        head_met_q <= 1'b0;
      end else begin
        complete_q <= complete_q | exec_hit;
        // Sticky, a later head change does not undo it
        head_met_q <= head_met_q | head_hit;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (alloc) begin
      tag_q     <= tag_n;
      is_load_q <= alloc_1 ? disp.is_load_1 : disp.is_load_2;
    end
    if (hit_1) begin
      addr_q  <= exec.addr_1;
      value_q <= exec.value_1;
    end else if (hit_2) begin
      addr_q  <= exec.addr_2;
      value_q <= exec.value_2;
    end
  end

  assign tag     = tag_q;
  assign addr    = addr_q;
  assign value   = value_q;
  assign is_load = is_load_q;
  assign ready   = valid_q & complete_q & (is_load_q | head_met_q);

endmodule

// File: verilog/lsq_ptr_ctrl.sv
// Depth must be a power of two so pointers wrap; dispatch while full is not guarded
`include "lsq_cfg.svh"

module lsq_ptr_ctrl import lsq_pkg::*; (
  input  logic                    clock,
  input  logic                    reset,
  lsq_disp_if.sink                disp,
  input  logic                    advance,
  output lsq_ptr_t                head,
  output logic [`LSQ_ENTRIES-1:0] alloc_1,
  output logic [`LSQ_ENTRIES-1:0] alloc_2,
  output logic [`LSQ_ENTRIES-1:0] clear,
  output logic                    full
);

  localparam int CNT_W = `LSQ_PTR_W + 1;
  localparam int FULL_LEVEL = `LSQ_ENTRIES - 1;

  typedef logic [CNT_W-1:0] count_t;

  lsq_ptr_t head_q;
  lsq_ptr_t tail_q;
  lsq_ptr_t slot_1;
  lsq_ptr_t slot_2;
  count_t   count_q;
  count_t   count_n;
  logic [1:0] disp_n;

  assign disp_n = {1'b0, disp.valid_1} + {1'b0, disp.valid_2};

  // Tail names the next free slot
  assign slot_1 = tail_q;
  assign slot_2 = disp.valid_1 ? tail_q + 1'b1 : tail_q;

  assign count_n = count_q + count_t'(disp_n) - count_t'(advance);

  always_ff @(posedge clock) begin
    if (reset) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      head_q  <= head_q + lsq_ptr_t'(advance);
      tail_q  <= tail_q + lsq_ptr_t'(disp_n);
      count_q <= count_n;
    end
  end

  // One-hot strobes per slot
  always_comb begin
    for (int i = 0; i < `LSQ_ENTRIES; i++) begin
      alloc_1[i] = disp.valid_1 & (slot_1 == lsq_ptr_t'(i));
      alloc_2[i] = disp.valid_2 & (slot_2 == lsq_ptr_t'(i));
      clear[i]   = advance & (head_q == lsq_ptr_t'(i));
    end
  end

  assign head = head_q;

  // Fewer than two free slots
  assign full = (count_q >= count_t'(FULL_LEVEL));

endmodule

// File: verilog/lsq_mem_fsm.sv
// Issues only the head slot in program order; one load outstanding, response number zero is idle
module lsq_mem_fsm import lsq_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         head_valid_ready,
  input  logic         head_is_load,
  input  rob_tag_t     head_tag,
  input  data_t        head_addr,
  input  data_t        head_value,
  input  mem_tag_t     mem_response,
  input  mem_tag_t     mem_data_tag,
  input  data_t        mem_data,
  output mem_command_t command,
  output data_t        mem_addr,
  output data_t        mem_wdata,
  output logic         advance,
  output logic         stall,
  output logic         result_valid,
  output rob_tag_t     result_tag,
  output data_t        result_data
);

  typedef enum logic {
    IDLE,
    WAIT_LOAD
  } state_t;

  state_t   state_q;
  state_t   state_n;
  mem_tag_t resp_q;

  logic issue;
  logic accepted;
  logic store_done;
  logic load_done;

  ////////////////////////////////////////
  // Command side
  ////////////////////////////////////////

  assign issue    = (state_q == IDLE) & head_valid_ready;
  assign accepted = issue & (mem_response != '0);

  always_comb begin
    command = MEM_NONE;
    if (issue) begin
      command = head_is_load ? MEM_LOAD : MEM_STORE;
    end
  end

  // Held steady by the head slot until accepted
  assign mem_addr  = head_addr;
  assign mem_wdata = head_value;

  ////////////////////////////////////////
  // Completion
  ////////////////////////////////////////

  assign store_done = accepted & ~head_is_load;
  assign load_done  = (state_q == WAIT_LOAD) & (mem_data_tag == resp_q);

  assign advance      = store_done | load_done;
  assign result_valid = load_done;
  assign result_tag   = head_tag;
  assign result_data  = mem_data;

  // Back-pressure, or a load still in flight
  assign stall = (issue & (mem_response == '0)) |
                 ((state_q == WAIT_LOAD) & ~load_done);

  always_comb begin
    state_n = state_q;
    case (state_q)
      IDLE:      if (accepted & head_is_load) state_n = WAIT_LOAD;
      WAIT_LOAD: if (load_done) state_n = IDLE;
      default:   state_n = IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= IDLE;
      resp_q  <= '0;
    end else begin
      state_q <= state_n;
      if (accepted & head_is_load) begin
        resp_q <= mem_response;
      end
    end
  end

endmodule

// File: verilog/lsq_top.sv
// No forwarding, disambiguation or flush; dispatch must stay off while full is high
`include "lsq_cfg.svh"

module lsq_top import lsq_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         disp_valid_1,
  input  rob_tag_t     disp_tag_1,
  input  logic         disp_is_load_1,
  input  logic         disp_valid_2,
  input  rob_tag_t     disp_tag_2,
  input  logic         disp_is_load_2,
  input  logic         ex_valid_1,
  input  rob_tag_t     ex_tag_1,
  input  data_t        ex_addr_1,
  input  data_t        ex_value_1,
  input  logic         ex_valid_2,
  input  rob_tag_t     ex_tag_2,
  input  data_t        ex_addr_2,
  input  data_t        ex_value_2,
  input  logic         rob_head_valid_1,
  input  rob_tag_t     rob_head_tag_1,
  input  logic         rob_head_valid_2,
  input  rob_tag_t     rob_head_tag_2,
  input  mem_tag_t     mem_response,
  input  mem_tag_t     mem_data_tag,
  input  data_t        mem_data,
  output mem_command_t mem_command,
  output data_t        mem_addr,
  output data_t        mem_wdata,
  output logic         result_valid,
  output rob_tag_t     result_tag,
  output data_t        result_data,
  output logic         stall,
  output logic         full
);

  lsq_disp_if disp_bus ();
  lsq_exec_if exec_bus ();

  logic [`LSQ_ENTRIES-1:0] alloc_1;
  logic [`LSQ_ENTRIES-1:0] alloc_2;
  logic [`LSQ_ENTRIES-1:0] clear;
  logic [`LSQ_ENTRIES-1:0] slot_is_load;
  logic [`LSQ_ENTRIES-1:0] slot_ready;
  rob_tag_t                slot_tag   [`LSQ_ENTRIES];
  data_t                   slot_addr  [`LSQ_ENTRIES];
  data_t                   slot_value [`LSQ_ENTRIES];

  lsq_ptr_t head;
  logic     advance;

  ////////////////////////////////////////
  // Flat ports onto the internal buses
  ////////////////////////////////////////

  assign disp_bus.valid_1   = disp_valid_1;
  assign disp_bus.tag_1     = disp_tag_1;
  assign disp_bus.is_load_1 = disp_is_load_1;
  assign disp_bus.valid_2   = disp_valid_2;
  assign disp_bus.tag_2     = disp_tag_2;
  assign disp_bus.is_load_2 = disp_is_load_2;

  assign exec_bus.valid_1 = ex_valid_1;
  assign exec_bus.tag_1   = ex_tag_1;
  assign exec_bus.addr_1  = ex_addr_1;
  assign exec_bus.value_1 = ex_value_1;
  assign exec_bus.valid_2 = ex_valid_2;
  assign exec_bus.tag_2   = ex_tag_2;
  assign exec_bus.addr_2  = ex_addr_2;
  assign exec_bus.value_2 = ex_value_2;

  ////////////////////////////////////////
  // Slots
  ////////////////////////////////////////

  for (genvar i = 0; i < `LSQ_ENTRIES; i++) begin : g_slot
    lsq_entry entry_i (
      .clock            (clock),
      .reset            (reset),
      .clear            (clear[i]),
      .alloc_1          (alloc_1[i]),
      .alloc_2          (alloc_2[i]),
      .disp             (disp_bus.sink),
      .exec             (exec_bus.sink),
      .rob_head_valid_1 (rob_head_valid_1),
      .rob_head_tag_1   (rob_head_tag_1),
      .rob_head_valid_2 (rob_head_valid_2),
      .rob_head_tag_2   (rob_head_tag_2),
      .tag              (slot_tag[i]),
      .addr             (slot_addr[i]),
      .value            (slot_value[i]),
      .is_load          (slot_is_load[i]),
      .ready            (slot_ready[i])
    );
  end

  lsq_ptr_ctrl ptr_ctrl_i (
    .clock   (clock),
    .reset   (reset),
    .disp    (disp_bus.sink),
    .advance (advance),
    .head    (head),
    .alloc_1 (alloc_1),
    .alloc_2 (alloc_2),
    .clear   (clear),
    .full    (full)
  );

  // Head slot fields straight into the memory FSM
  lsq_mem_fsm mem_fsm_i (
    .clock            (clock),
    .reset            (reset),
    .head_valid_ready (slot_ready[head]),
    .head_is_load     (slot_is_load[head]),
    .head_tag         (slot_tag[head]),
    .head_addr        (slot_addr[head]),
    .head_value       (slot_value[head]),
    .mem_response     (mem_response),
    .mem_data_tag     (mem_data_tag),
    .mem_data         (mem_data),
    .command          (mem_command),
    .mem_addr         (mem_addr),
    .mem_wdata        (mem_wdata),
    .advance          (advance),
    .stall            (stall),
    .result_valid     (result_valid),
    .result_tag       (result_tag),
    .result_data      (result_data)
  );

endmodule

// File: dv/lsq_mem_responder.sv
// Testbench memory model: one load in flight, response numbers rotate over the nonzero values
module lsq_mem_responder import lsq_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  mem_command_t command,
  input  data_t        addr,
  input  data_t        wdata,
  output mem_tag_t     response,
  output mem_tag_t     data_tag,
  output data_t        data
);

  data_t    store_mem [data_t];
  mem_tag_t next_num = mem_tag_t'(1);
  mem_tag_t load_num;
  data_t    load_word;
  logic     load_pending = 1'b0;
  int       accept_wait = 0;
  int       return_wait = 0;

  // Contents of a word that was never written
  function automatic data_t fill_pattern(input data_t a);
    return {a[31:0], a[63:32]} ^ 64'h5A5A_C3C3_0F0F_9669;
  endfunction

  initial begin
    response = '0;
    data_tag = '0;
    data     = '0;
  end

  // Responses change just after the edge
  always @(posedge clock) begin
    #1;
    response = '0;
    data_tag = '0;
    data     = '0;
    if (!reset) begin
      if (command != MEM_NONE) begin
        if (accept_wait == 0) response = next_num;
        else accept_wait--;
      end
      if (load_pending) begin
        if (return_wait == 0) begin
          data_tag = load_num;
          data     = load_word;
        end else begin
          return_wait--;
        end
      end
    end
  end

  // Acceptance and load return seen mid-cycle
  always @(negedge clock) begin
    if (!reset && command != MEM_NONE && response != '0) begin
      if (command == MEM_STORE) begin
        store_mem[addr] = wdata;
      end else begin
        load_pending = 1'b1;
        load_num     = response;
        load_word    = store_mem.exists(addr) ? store_mem[addr] : fill_pattern(addr);
        return_wait  = $urandom_range(0, 6);
      end
      accept_wait = $urandom_range(0, 3);
      next_num    = (next_num == '1) ? mem_tag_t'(1) : next_num + 1'b1;
    end
    if (data_tag != '0) load_pending = 1'b0;
  end

endmodule

// File: dv/lsq_tb.sv
// Random program of NUM_OPS loads and stores; checks are sampled at the falling clock edge
`include "lsq_cfg.svh"

module lsq_tb import lsq_pkg::*; ();

  localparam int NUM_OPS    = 300;
  localparam int CLK_PERIOD = 8;
  localparam longint WATCHDOG_TIME = longint'(NUM_OPS) * 60 * CLK_PERIOD;

  logic clock = 1'b0;
  logic reset;
  logic disp_valid_1, disp_is_load_1, disp_valid_2, disp_is_load_2;
  rob_tag_t disp_tag_1, disp_tag_2;
  logic ex_valid_1, ex_valid_2;
  rob_tag_t ex_tag_1, ex_tag_2;
  data_t ex_addr_1, ex_value_1, ex_addr_2, ex_value_2;
  logic rob_head_valid_1, rob_head_valid_2;
  rob_tag_t rob_head_tag_1, rob_head_tag_2;
  mem_tag_t mem_response, mem_data_tag;
  data_t mem_data, mem_addr, mem_wdata, result_data;
  mem_command_t mem_command;
  logic result_valid, stall, full;
  rob_tag_t result_tag;

  // Program and model state
  rob_tag_t op_tag [NUM_OPS];
  logic     op_load [NUM_OPS];
  data_t    op_addr [NUM_OPS];
  data_t    op_value [NUM_OPS];
  bit       rob_seen [NUM_OPS];
  data_t    model_mem [data_t];
  int       exec_pend [$];
  int disp_k = 0, issue_k = 0, retire_k = 0, occ = 0;
  int load_k;
  bit load_wait = 0;
  mem_tag_t load_resp = '0;
  data_t exp_data;
  mem_command_t prev_cmd = MEM_NONE;
  mem_tag_t prev_resp = '0;
  data_t prev_addr, prev_wdata;
  int err_cmd = 0, err_result = 0, err_hold = 0, err_full = 0;
  int err_store = 0, err_reset = 0, err_stall = 0;

  always #(CLK_PERIOD / 2) clock = ~clock;

  lsq_top dut_i (.*);

  lsq_mem_responder responder_i (
    .clock (clock), .reset (reset), .command (mem_command), .addr (mem_addr),
    .wdata (mem_wdata), .response (mem_response), .data_tag (mem_data_tag), .data (mem_data)
  );

  function automatic data_t expected_fill(input data_t a);
    return {a[31:0], a[63:32]} ^ 64'h5A5A_C3C3_0F0F_9669;
  endfunction

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic pick_exec(output logic v, output rob_tag_t t, output data_t a, output data_t d);
    int idx;
    int k;
    v = 1'b0;
    t = '0;
    a = '0;
    d = '0;
    if (exec_pend.size() > 0 && $urandom_range(0, 1) == 1) begin
      idx = $urandom_range(0, exec_pend.size() - 1);
      k = exec_pend[idx];
      exec_pend.delete(idx);
      v = 1'b1;
      t = op_tag[k];
      a = op_addr[k];
      d = op_value[k];
    end
  endtask

  task automatic drive_cycle();
    int choice;
    choice = $urandom_range(0, 3);
    disp_valid_1 = 1'b0;
    disp_valid_2 = 1'b0;
    // Lane 1 always holds the older operation
    if (!full && disp_k < NUM_OPS && (choice == 1 || choice == 3)) begin
      disp_valid_1   = 1'b1;
      disp_tag_1     = op_tag[disp_k];
      disp_is_load_1 = op_load[disp_k];
      exec_pend.push_back(disp_k);
      disp_k++;
    end
    if (!full && disp_k < NUM_OPS && (choice == 2 || choice == 3)) begin
      disp_valid_2   = 1'b1;
      disp_tag_2     = op_tag[disp_k];
      disp_is_load_2 = op_load[disp_k];
      exec_pend.push_back(disp_k);
      disp_k++;
    end
    pick_exec(ex_valid_1, ex_tag_1, ex_addr_1, ex_value_1);
    pick_exec(ex_valid_2, ex_tag_2, ex_addr_2, ex_value_2);
    // Oldest store reaches a reorder head once everything older has left
    rob_head_valid_1 = 1'b0;
    rob_head_valid_2 = 1'b0;
    rob_head_tag_1   = rob_tag_t'($urandom);
    rob_head_tag_2   = rob_tag_t'($urandom);
    if (retire_k < disp_k && !op_load[retire_k] && $urandom_range(0, 3) != 0) begin
      if ($urandom_range(0, 1) == 1) begin
        rob_head_valid_2 = 1'b1;
        rob_head_tag_2   = op_tag[retire_k];
      end else begin
        rob_head_valid_1 = 1'b1;
        rob_head_tag_1   = op_tag[retire_k];
      end
    end
  endtask

  ////////////////////////////////////////
  // Model and checks
  ////////////////////////////////////////

  task automatic monitor_cycle();
    int   retired;
    logic full_exp;
    logic stall_exp;
    retired   = 0;
    full_exp  = (`LSQ_ENTRIES - occ) < 2;
    // Back-pressure, or a load whose data has not come back yet
    stall_exp = (mem_command != MEM_NONE && mem_response == '0) ||
                (load_wait && mem_data_tag != load_resp);
    assert (full == full_exp)
      else begin
        err_full++;
        $display("ERR full got %h expected %h", full, full_exp);
      end
    assert (stall == stall_exp)
      else begin
        err_stall++;
        $display("ERR stall got %h expected %h", stall, stall_exp);
      end
    if (prev_cmd != MEM_NONE && prev_resp == '0) begin
      assert (mem_command == prev_cmd && mem_addr == prev_addr && mem_wdata == prev_wdata)
        else begin
          err_hold++;
          $display("ERR mem_command/mem_addr/mem_wdata got %h/%h/%h expected %h/%h/%h",
                   mem_command, mem_addr, mem_wdata, prev_cmd, prev_addr, prev_wdata);
        end
    end
    if (mem_command == MEM_STORE && issue_k < disp_k) begin
      assert (rob_seen[issue_k])
        else begin
          err_store++;
          $display("Store issued before its tag reached a reorder head");
        end
    end
    if (mem_command != MEM_NONE && mem_response != '0) begin
      assert (issue_k < disp_k)
        else begin
          err_cmd++;
          $display("Memory command accepted with no operation in the queue");
        end
      if (issue_k < disp_k) begin
        assert (mem_command == (op_load[issue_k] ? MEM_LOAD : MEM_STORE))
          else begin
            err_cmd++;
            $display("ERR mem_command got %h expected %h", mem_command,
                     op_load[issue_k] ? MEM_LOAD : MEM_STORE);
          end
        assert (mem_addr == op_addr[issue_k])
          else begin
            err_cmd++;
            $display("ERR mem_addr got %h expected %h", mem_addr, op_addr[issue_k]);
          end
        if (op_load[issue_k]) begin
          load_k    = issue_k;
          load_wait = 1'b1;
          load_resp = mem_response;
          exp_data  = model_mem.exists(op_addr[issue_k]) ? model_mem[op_addr[issue_k]] :
                      expected_fill(op_addr[issue_k]);
        end else begin
          assert (mem_wdata == op_value[issue_k])
            else begin
              err_cmd++;
              $display("ERR mem_wdata got %h expected %h", mem_wdata, op_value[issue_k]);
            end
          model_mem[op_addr[issue_k]] = op_value[issue_k];
          retire_k++;
          retired++;
        end
        issue_k++;
      end
    end
    if (result_valid) begin
      assert (load_wait)
        else begin
          err_result++;
          $display("Load result returned with no load outstanding");
        end
      if (load_wait) begin
        assert (result_tag == op_tag[load_k])
          else begin
            err_result++;
            $display("ERR result_tag got %h expected %h", result_tag, op_tag[load_k]);
          end
        assert (result_data == exp_data)
          else begin
            err_result++;
            $display("ERR result_data got %h expected %h", result_data, exp_data);
          end
        load_wait = 1'b0;
        retire_k++;
        retired++;
      end
    end
    for (int k = retire_k; k < disp_k; k++) begin
      if ((rob_head_valid_1 && rob_head_tag_1 == op_tag[k]) ||
          (rob_head_valid_2 && rob_head_tag_2 == op_tag[k])) rob_seen[k] = 1'b1;
    end
    occ = occ + int'(disp_valid_1) + int'(disp_valid_2) - retired;
    prev_cmd   = mem_command;
    prev_resp  = mem_response;
    prev_addr  = mem_addr;
    prev_wdata = mem_wdata;
  endtask

  always @(negedge clock) begin
    if (!reset) monitor_cycle();
  end

  task automatic report_counts();
    $display({"Errors: command %0d, result %0d, hold %0d, full %0d, store order %0d, ",
              "reset %0d, stall %0d"},
             err_cmd, err_result, err_hold, err_full, err_store, err_reset, err_stall);
  endtask

  initial begin
    #(WATCHDOG_TIME);
    $display("Timeout: only %0d of %0d operations left the queue", retire_k, NUM_OPS);
    report_counts();
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    void'($urandom(1));
    reset = 1'b1;
    {disp_valid_1, disp_is_load_1, disp_valid_2, disp_is_load_2} = '0;
    {disp_tag_1, disp_tag_2, ex_tag_1, ex_tag_2} = '0;
    {ex_valid_1, ex_valid_2, rob_head_valid_1, rob_head_valid_2} = '0;
    {ex_addr_1, ex_value_1, ex_addr_2, ex_value_2} = '0;
    {rob_head_tag_1, rob_head_tag_2} = '0;
    // Tags stay unique over any 32 consecutive operations; small address pool with strays
    for (int k = 0; k < NUM_OPS; k++) begin
      op_tag[k]   = rob_tag_t'((k * 7 + 3) % (1 << `LSQ_ROB_TAG_W));
      op_load[k]  = $urandom_range(0, 1);
      op_addr[k]  = ($urandom_range(0, 3) == 0) ? {$urandom, $urandom} :
                    64'h1000 + 8 * $urandom_range(0, 7);
      op_value[k] = {$urandom, $urandom};
      rob_seen[k] = 1'b0;
    end
    repeat (8) @(posedge clock);
    #1;
    reset = 1'b0;
    @(negedge clock);
    assert (mem_command == MEM_NONE && !result_valid && !stall && !full)
      else begin
        err_reset++;
        $display("ERR mem_command/result_valid/stall/full got %h/%h/%h/%h expected 0/0/0/0",
                 mem_command, result_valid, stall, full);
      end
    while (retire_k < NUM_OPS) begin
      @(posedge clock);
      #1;
      drive_cycle();
    end
    repeat (4) @(posedge clock);
    report_counts();
    if (err_cmd + err_result + err_hold + err_full +
        err_store + err_reset + err_stall == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+verilog
verilog/lsq_pkg.sv
verilog/lsq_if.sv
verilog/lsq_entry.sv
verilog/lsq_ptr_ctrl.sv
verilog/lsq_mem_fsm.sv
verilog/lsq_top.sv
dv/lsq_mem_responder.sv
dv/lsq_tb.sv

// File: Bender.yml
package:
  name: lsq

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/lsq_pkg.sv
      - verilog/lsq_if.sv
      - verilog/lsq_entry.sv
      - verilog/lsq_ptr_ctrl.sv
      - verilog/lsq_mem_fsm.sv
      - verilog/lsq_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/lsq_mem_responder.sv
      - dv/lsq_tb.sv
